/* source/packet_rom.hex */
// each line is one link_packet_t word, msb first, 18 hex digits.
// digits from the left are op, addr (4), data (8), mask, dest x, dest y and src (2, zero).
01000c0de0000f1100
01004c0de0101f1200
01008c0de0202f1300
0100cc0de0303f2100
01010c0de0404f2200
01014c0de0505f2300
01018c0de0606f3100
0101cc0de0707f3200
21020c0de0808f0100
01024c0de0909c1300
01028c0de0a0a32000
0102cc0de0b0b10200
21030c0de0c0cf0300
01034c0de0d0d84000
01038c0de0e0e14100
0103cc0de0f0ff4200

/* project.f */
source/streamer_pkg.sv
source/packet_rom.sv
source/credit_counter.sv
source/link_endpoint.sv
source/streamer_ctrl.sv
source/packet_streamer_top.sv
verification/tb_packet_streamer.sv

/* Bender.yml */
package:
  name: packet_streamer

sources:
  - source/streamer_pkg.sv
  - source/packet_rom.sv
  - source/credit_counter.sv
  - source/link_endpoint.sv
  - source/streamer_ctrl.sv
  - source/packet_streamer_top.sv
  - target: simulation
    files:
      - verification/tb_packet_streamer.sv

/* verification/tb_packet_streamer.sv */
`timescale 1ns/1ps

module tb_packet_streamer;

   logic                                  clk;
   logic                                  rst_i;
   logic [streamer_pkg::X_CORD_WIDTH-1:0] my_x_i;
   logic [streamer_pkg::Y_CORD_WIDTH-1:0] my_y_i;
   logic                                  link_v_o;
   streamer_pkg::link_packet_t            link_pkt_o;
   logic                                  link_ready_i;
   logic                                  in_v_i;
   streamer_pkg::link_packet_t            in_pkt_i;
   logic                                  credit_return_i;
   logic                                  done_o;

   logic [$bits(streamer_pkg::link_packet_t)-1:0] rom_words [0:streamer_pkg::ROM_WORDS-1];

   integer                     seed;
   integer                     ready_bits;
   int                         value_errors;
   int                         other_errors;
   bit                         timed_out;
   string                      test_name;
   int                         xfer_count;
   int                         returned_count;
   bit                         returns_enabled;
   bit                         ready_random;
   bit                         return_due;
   int                         ret_q [$];
   bit                         hold_v;
   streamer_pkg::link_packet_t held_pkt;

   packet_streamer_top i_packet_streamer_top
   (
      .clk_i           (clk),
      .rst_i           (rst_i),
      .my_x_i          (my_x_i),
      .my_y_i          (my_y_i),
      .link_v_o        (link_v_o),
      .link_pkt_o      (link_pkt_o),
      .link_ready_i    (link_ready_i),
      .in_v_i          (in_v_i),
      .in_pkt_i        (in_pkt_i),
      .credit_return_i (credit_return_i),
      .done_o          (done_o)
   );

   always #20 clk = ~clk;

   // ----------------------------------------
   // reference and compare tasks
   // ----------------------------------------
   function automatic streamer_pkg::link_packet_t expected_packet(input int index);
      streamer_pkg::link_packet_t pkt;
      pkt       = rom_words[index];
      pkt.src_x = 4'd3;  // the node sits at x 3, y 5.
      pkt.src_y = 4'd5;
      return pkt;
   endfunction

   task automatic check_packet(input string name, input streamer_pkg::link_packet_t exp,
                               input streamer_pkg::link_packet_t act);
      if (act !== exp)
      begin
         value_errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         value_errors++;
         $display("ERR %s expected %b actual %b", name, exp, act);
      end
   endtask

   // ----------------------------------------
   // network model
   // ----------------------------------------
   always @(posedge clk)
   begin
      #2;
      credit_return_i = return_due;
      ready_bits      = $random(seed);
      link_ready_i    = ready_random ? ready_bits[0] : 1'b1;
   end

   // a transfer seen here takes place at the next rising edge.
   always @(negedge clk)
   begin
      if (!rst_i)
      begin
         if (hold_v)
         begin
            check_bit(test_name, 1'b1, link_v_o);
            check_packet(test_name, held_pkt, link_pkt_o);
         end
         hold_v   = link_v_o & ~link_ready_i;
         held_pkt = link_pkt_o;
         if (link_v_o && link_ready_i)
         begin
            if (xfer_count < streamer_pkg::ROM_WORDS)
            begin
               check_packet(test_name, expected_packet(xfer_count), link_pkt_o);
            end
            else
            begin
               other_errors++;
               $display("packet sent past the end of the table in %s", test_name);
            end
            xfer_count++;
            ret_q.push_back(1 + ({$random(seed)} % 6));
         end
         if (xfer_count - returned_count > streamer_pkg::MAX_OUT_CREDITS)
         begin
            other_errors++;
            $display("too many packets outstanding in %s", test_name);
         end
         foreach (ret_q[k])
         begin
            if (ret_q[k] > 0)
            begin
               ret_q[k]--;
            end
         end
         return_due = 1'b0;
         if (returns_enabled && ret_q.size() > 0 && ret_q[0] == 0)
         begin
            ret_q.delete(0);  // one return pulse per cycle at most.
            return_due = 1'b1;
            returned_count++;
         end
      end
   end

   // ----------------------------------------
   // stimulus and waits
   // ----------------------------------------
   task automatic send_inbound(input streamer_pkg::packet_op_e op,
                               input logic [streamer_pkg::ADDR_WIDTH-1:0] addr,
                               input logic [streamer_pkg::DATA_WIDTH-1:0] data);
      streamer_pkg::link_packet_t pkt;
      pkt        = '0;
      pkt.op     = op;
      pkt.addr   = addr;
      pkt.data   = data;
      pkt.mask   = '1;
      pkt.dest_x = 4'd3;
      pkt.dest_y = 4'd5;
      @(posedge clk);
      #2;
      in_pkt_i = pkt;
      in_v_i   = 1'b1;
      @(posedge clk);
      #2;
      in_v_i = 1'b0;
   endtask

   task automatic wait_transfers(input int target, input int limit, input string what);
      int cycles;
      cycles = 0;
      while (xfer_count < target && cycles < limit)
      begin
         @(posedge clk);
         cycles++;
      end
      if (xfer_count < target)
      begin
         other_errors++;
         timed_out = 1'b1;
         $display("timeout while waiting for %s", what);
      end
   endtask

   task automatic wait_done(input int limit);
      int cycles;
      cycles = 0;
      while (done_o !== 1'b1 && cycles < limit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (done_o !== 1'b1)
      begin
         other_errors++;
         timed_out = 1'b1;
         $display("timeout while waiting for done_o to rise");
      end
   endtask

   task automatic run_tests();
      int mark;
      test_name = "frozen";
      repeat (20)
      begin
         @(negedge clk);
         check_bit(test_name, 1'b0, link_v_o);
         check_bit(test_name, 1'b0, done_o);
      end
      test_name = "noise";
      send_inbound(streamer_pkg::OP_STORE, streamer_pkg::FREEZE_ADDR, 32'h0);
      send_inbound(streamer_pkg::OP_LOAD, streamer_pkg::FREEZE_ADDR, 32'h0);
      send_inbound(streamer_pkg::OP_CONFIG, streamer_pkg::FREEZE_ADDR + 16'h0010, 32'h0);
      repeat (10)
      begin
         @(negedge clk);
         check_bit(test_name, 1'b0, link_v_o);
      end
      send_inbound(streamer_pkg::OP_CONFIG, streamer_pkg::FREEZE_ADDR, 32'h0);
      wait_transfers(1, 100, "the first packet after unfreeze");
      if (timed_out)
      begin
         return;
      end
      test_name = "order";
      wait_transfers(6, 300, "six packets in order");
      if (timed_out)
      begin
         return;
      end
      test_name = "credit";
      #2;
      returns_enabled = 1'b0;
      wait_transfers(returned_count + streamer_pkg::MAX_OUT_CREDITS, 300,
                     "the credit pool to drain");
      if (timed_out)
      begin
         return;
      end
      repeat (20)
      begin
         @(negedge clk);
         check_bit(test_name, 1'b0, link_v_o);  // no credit left, so nothing is sent.
      end
      @(posedge clk);
      #2;
      returns_enabled = 1'b1;
      wait_transfers(xfer_count + 1, 100, "sending to resume after credit returns");
      if (timed_out)
      begin
         return;
      end
      test_name = "pause";
      send_inbound(streamer_pkg::OP_CONFIG, streamer_pkg::FREEZE_ADDR, 32'h1);
      mark = xfer_count;
      repeat (20) @(posedge clk);
      if (xfer_count > mark + 1)
      begin
         other_errors++;
         $display("more than one packet left the node while it was paused");
      end
      @(negedge clk);
      check_bit(test_name, 1'b0, link_v_o);
      test_name = "resume";
      send_inbound(streamer_pkg::OP_CONFIG, streamer_pkg::FREEZE_ADDR, 32'h0);
      wait_transfers(xfer_count + 1, 100, "sending to resume after unfreeze");
      if (timed_out)
      begin
         return;
      end
      test_name = "done";
      wait_done(400);
      if (timed_out)
      begin
         return;
      end
      wait_transfers(streamer_pkg::ROM_WORDS, 100, "the last packet");
      if (timed_out)
      begin
         return;
      end
      #2;
      ready_random = 1'b0;
      repeat (30)
      begin
         @(negedge clk);
         check_bit(test_name, 1'b1, done_o);
         check_bit(test_name, 1'b0, link_v_o);
      end
   endtask

   initial
   begin
      clk             = 1'b0;
      rst_i           = 1'b1;
      my_x_i          = 4'd3;
      my_y_i          = 4'd5;
      link_ready_i    = 1'b0;
      in_v_i          = 1'b0;
      in_pkt_i        = '0;
      credit_return_i = 1'b0;
      seed            = 44;
      value_errors    = 0;
      other_errors    = 0;
      timed_out       = 1'b0;
      xfer_count      = 0;
      returned_count  = 0;
      returns_enabled = 1'b1;
      ready_random    = 1'b1;
      return_due      = 1'b0;
      hold_v          = 1'b0;
      held_pkt        = '0;
      test_name       = "reset";
      $readmemh("source/packet_rom.hex", rom_words);
      repeat (2) @(posedge clk);
      #2;
      rst_i = 1'b0;
      run_tests();
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* source/packet_streamer_top.sv */
`timescale 1ns/1ps

module packet_streamer_top
(
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic [streamer_pkg::X_CORD_WIDTH-1:0] my_x_i,
   input  logic [streamer_pkg::Y_CORD_WIDTH-1:0] my_y_i,
   output logic                                link_v_o,
   output streamer_pkg::link_packet_t          link_pkt_o,
   input  logic                                link_ready_i,
   input  logic                                in_v_i,
   input  streamer_pkg::link_packet_t          in_pkt_i,
   input  logic                                credit_return_i,
   output logic                                done_o
);

   logic [streamer_pkg::ROM_ADDR_WIDTH-1:0] rom_addr;
   streamer_pkg::link_packet_t           rom_pkt;
   logic                                 send_v;
   logic                                 send_ready;
   logic                                 send_event;
   logic                                 credits_avail;
   logic                                 freeze;

   assign send_event = send_v & send_ready;  // one credit leaves per send.

   packet_rom i_packet_rom
   (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .addr_i (rom_addr),
      .pkt_o  (rom_pkt)
   );

   credit_counter i_credit_counter
   (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .send_i   (send_event),
      .return_i (credit_return_i),
      .avail_o  (credits_avail)
   );

   link_endpoint i_link_endpoint
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .my_x_i       (my_x_i),
      .my_y_i       (my_y_i),
      .send_v_i     (send_v),
      .send_pkt_i   (rom_pkt),
      .send_ready_o (send_ready),
      .link_ready_i (link_ready_i),
      .link_v_o     (link_v_o),
      .link_pkt_o   (link_pkt_o),
      .in_v_i       (in_v_i),
      .in_pkt_i     (in_pkt_i),
      .freeze_o     (freeze)
   );

   streamer_ctrl i_streamer_ctrl
   (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .freeze_i        (freeze),
      .send_ready_i    (send_ready),
      .credits_avail_i (credits_avail),
      .rom_addr_o      (rom_addr),
      .send_v_o        (send_v),
      .done_o          (done_o)
   );

endmodule

/* source/streamer_ctrl.sv */
`timescale 1ns/1ps

module streamer_ctrl
(
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  freeze_i,
   input  logic                                  send_ready_i,
   input  logic                                  credits_avail_i,
   output logic [streamer_pkg::ROM_ADDR_WIDTH-1:0] rom_addr_o,
   output logic                                  send_v_o,
   output logic                                  done_o
);

   localparam logic [streamer_pkg::ROM_ADDR_WIDTH-1:0] LAST_ADDR =
      streamer_pkg::ROM_ADDR_WIDTH'(streamer_pkg::ROM_WORDS - 1);

   streamer_pkg::stream_state_e         state_q;
   streamer_pkg::stream_state_e         state_d;
   logic [streamer_pkg::ROM_ADDR_WIDTH-1:0] addr_q;
   logic                                send;
   logic                                last_send;

   // freeze also gates directly, so a pause stops sending in the same cycle.
   assign send_v_o  = (state_q == streamer_pkg::ST_STREAM) & ~freeze_i & credits_avail_i;
   assign send      = send_v_o & send_ready_i;
   assign last_send = send & (addr_q == LAST_ADDR);

   // ----------------------------------------
   // state machine
   // ----------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         streamer_pkg::ST_FROZEN:
         begin
            if (~freeze_i)
            begin
               state_d = streamer_pkg::ST_STREAM;
            end
         end
         streamer_pkg::ST_STREAM:
         begin
            if (last_send)
            begin
               state_d = streamer_pkg::ST_DONE;
            end
            else if (freeze_i)
            begin
               state_d = streamer_pkg::ST_FROZEN;  // paused, address is kept.
            end
         end
         default:
         begin
            state_d = streamer_pkg::ST_DONE;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q <= streamer_pkg::ST_FROZEN;
         addr_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (send & ~last_send)
         begin
            addr_q <= addr_q + 1'b1;  // holds on the final entry.
         end
      end
   end

   assign rom_addr_o = addr_q;
   assign done_o     = (state_q == streamer_pkg::ST_DONE);

endmodule

/* source/link_endpoint.sv */
`timescale 1ns/1ps

module link_endpoint
(
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic [streamer_pkg::X_CORD_WIDTH-1:0] my_x_i,
   input  logic [streamer_pkg::Y_CORD_WIDTH-1:0] my_y_i,
   input  logic                                send_v_i,
   input  streamer_pkg::link_packet_t          send_pkt_i,
   output logic                                send_ready_o,
   input  logic                                link_ready_i,
   output logic                                link_v_o,
   output streamer_pkg::link_packet_t          link_pkt_o,
   input  logic                                in_v_i,
   input  streamer_pkg::link_packet_t          in_pkt_i,
   output logic                                freeze_o
);

   logic                       out_v_q;
   streamer_pkg::link_packet_t out_pkt_q;
   streamer_pkg::link_packet_t stamped_pkt;
   logic                       send;
   logic                       freeze_q;
   logic                       freeze_hit;

   // ----------------------------------------
   // outbound register
   // ----------------------------------------
   assign send_ready_o = ~out_v_q | link_ready_i;  // empty, or drained this cycle.
   assign send         = send_v_i & send_ready_o;

   always_comb
   begin
      stamped_pkt       = send_pkt_i;
      stamped_pkt.src_x = my_x_i;
      stamped_pkt.src_y = my_y_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         out_v_q <= 1'b0;
      end
      else if (send)
      begin
         out_v_q <= 1'b1;
      end
      else if (link_ready_i)
      begin
         out_v_q <= 1'b0;  // packet taken by the network.
      end
   end

   // payload only moves on a send, so it stays stable under back-pressure.
   always_ff @(posedge clk_i)
   begin
      if (send)
      begin
         out_pkt_q <= stamped_pkt;
      end
   end

   assign link_v_o   = out_v_q;
   assign link_pkt_o = out_pkt_q;

   // ----------------------------------------
   // inbound decode
   // ----------------------------------------
   // every inbound packet is absorbed, only a freeze write has an effect.
   assign freeze_hit = in_v_i
                     & (in_pkt_i.op == streamer_pkg::OP_CONFIG)
                     & (in_pkt_i.addr == streamer_pkg::FREEZE_ADDR);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         freeze_q <= 1'b1;  // node comes up frozen.
      end
      else if (freeze_hit)
      begin
         freeze_q <= in_pkt_i.data[0];
      end
   end

   assign freeze_o = freeze_q;

endmodule

/* source/credit_counter.sv */
`timescale 1ns/1ps

module credit_counter
(
   input  logic clk_i,
   input  logic rst_i,
   input  logic send_i,
   input  logic return_i,
   output logic avail_o
);

   localparam logic [streamer_pkg::CREDIT_WIDTH-1:0] CREDITS_FULL =
      streamer_pkg::CREDIT_WIDTH'(streamer_pkg::MAX_OUT_CREDITS);

   logic [streamer_pkg::CREDIT_WIDTH-1:0] count_q;

   // ----------------------------------------
   // free credit count
   // ----------------------------------------
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         count_q <= CREDITS_FULL;  // whole pool is free after reset.
      end
      else
      begin
         case ({send_i, return_i})
            2'b10:
            begin
               if (count_q != '0)
               begin
                  count_q <= count_q - 1'b1;
               end
            end
            2'b01:
            begin
               if (count_q != CREDITS_FULL)
               begin
                  count_q <= count_q + 1'b1;  // saturates at the pool size.
               end
            end
            default:
            begin
               count_q <= count_q;  // send and return cancel out.
            end
         endcase
      end
   end

   assign avail_o = (count_q != '0);

endmodule

/* source/packet_rom.sv */
`timescale 1ns/1ps

module packet_rom
(
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic [streamer_pkg::ROM_ADDR_WIDTH-1:0] addr_i,
   output streamer_pkg::link_packet_t            pkt_o
);

   // ----------------------------------------
   // packet table
   // ----------------------------------------
   logic [$bits(streamer_pkg::link_packet_t)-1:0] rom_q [0:streamer_pkg::ROM_WORDS-1];

   initial
   begin
      $readmemh("source/packet_rom.hex", rom_q);  // src fields in the file are zero.
   end

   // the read is asynchronous, the controller sees the entry in the same cycle.
   assign pkt_o = streamer_pkg::link_packet_t'(rom_q[addr_i]);

endmodule

/* source/streamer_pkg.sv */
package streamer_pkg;

   // ----------------------------------------
   // link field sizes
   // ----------------------------------------
   localparam int X_CORD_WIDTH = 4;
   localparam int Y_CORD_WIDTH = 4;
   localparam int ADDR_WIDTH   = 16;
   localparam int DATA_WIDTH   = 32;
   localparam int MASK_WIDTH   = DATA_WIDTH / 8;  // one bit per data byte.

   // ----------------------------------------
   // packet table and credit pool
   // ----------------------------------------
   localparam int ROM_WORDS       = 16;
   localparam int ROM_ADDR_WIDTH  = $clog2(ROM_WORDS);
   localparam int MAX_OUT_CREDITS = 4;
   localparam int CREDIT_WIDTH    = $clog2(MAX_OUT_CREDITS + 1);  // holds zero up to the full pool.

   // configuration space location of the freeze register.
   localparam logic [ADDR_WIDTH-1:0] FREEZE_ADDR = 16'h0100;

   // ----------------------------------------
   // opcodes and states
   // ----------------------------------------
   typedef enum logic [1:0]
   {
      OP_STORE  = 2'b00,
      OP_LOAD   = 2'b01,
      OP_CONFIG = 2'b10
   } packet_op_e;

   typedef enum logic [1:0]
   {
      ST_FROZEN = 2'b00,  // waiting for the freeze register to clear.
      ST_STREAM = 2'b01,
      ST_DONE   = 2'b10   // table fully sent, held until reset.
   } stream_state_e;

   // ----------------------------------------
   // mesh packet, 70 bits, msb first
   // ----------------------------------------
   typedef struct packed
   {
      packet_op_e              op;
      logic [ADDR_WIDTH-1:0]   addr;
      logic [DATA_WIDTH-1:0]   data;
      logic [MASK_WIDTH-1:0]   mask;
      logic [X_CORD_WIDTH-1:0] dest_x;
      logic [Y_CORD_WIDTH-1:0] dest_y;
      logic [X_CORD_WIDTH-1:0] src_x;  // stamped by the sending node.
      logic [Y_CORD_WIDTH-1:0] src_y;
   } link_packet_t;

endpackage
